/* verif/rv_alu_patterns.mem */
// Columns: instr rs1_val rs2_val pc exp_value exp_illegal (all hex)
// Expected rd is instr[11:7]
002081B3 12345678 11111111 00000100 23456789 0 // add x3
002081B3 FFFFFFFF 00000002 00000104 00000001 0 // add wraps
40208233 00000003 00000005 00000108 FFFFFFFE 0 // sub x4
40208233 80000000 00000001 0000010C 7FFFFFFF 0 // sub wraps
0020A2B3 FFFFFFFF 00000001 00000110 00000001 0 // slt -1 < 1
0020B333 FFFFFFFF 00000001 00000114 00000000 0 // sltu
0020A2B3 00000005 80000000 00000118 00000000 0 // slt
0020B333 00000005 80000000 0000011C 00000001 0 // sltu
0020C3B3 F0F0F0F0 0FF00FF0 00000120 FF00FF00 0 // xor x7
0020E433 F0000001 0F000010 00000124 FF000011 0 // or x8
0020F4B3 FFFF0000 12345678 00000128 12340000 0 // and x9
00209533 00000001 0000001F 0000012C 80000000 0 // sll x10
00209533 00000003 00000024 00000130 00000030 0 // sll, low 5 bits only
0020D5B3 80000000 00000004 00000134 08000000 0 // srl x11
4020D633 80000000 00000004 00000138 F8000000 0 // sra sign fill
4020D633 7FFFFFFF 0000001F 0000013C 00000000 0 // sra
FFF08693 00000010 5A5A5A5A 00000140 0000000F 0 // addi -1
7FF08713 00000001 5A5A5A5A 00000144 00000800 0 // addi 0x7ff
FFE0A793 FFFFFFFF 5A5A5A5A 00000148 00000000 0 // slti -2
FFF0B813 00000005 5A5A5A5A 0000014C 00000001 0 // sltiu
FFF0C893 12345678 5A5A5A5A 00000150 EDCBA987 0 // xori -1
0F00E913 00000A05 5A5A5A5A 00000154 00000AF5 0 // ori
8000F993 12345FFF 5A5A5A5A 00000158 12345800 0 // andi sign-extended
00809A13 00ABCDEF 5A5A5A5A 0000015C ABCDEF00 0 // slli 8
00C0DA93 F0000000 5A5A5A5A 00000160 000F0000 0 // srli 12
40C0DB13 F0000000 5A5A5A5A 00000164 FFFF0000 0 // srai 12
12345BB7 DEADBEEF 5A5A5A5A 00000168 12345000 0 // lui
00010C17 DEADBEEF 5A5A5A5A 00001234 00011234 0 // auipc
FFFFFC97 DEADBEEF 5A5A5A5A 00002000 00001000 0 // auipc negative
00208463 AAAAAAAA 55555555 00000174 00000000 1 // beq
0040A283 AAAAAAAA 55555555 00000178 00000000 1 // lw
00000073 AAAAAAAA 55555555 0000017C 00000000 1 // ecall
022081B3 AAAAAAAA 55555555 00000180 00000000 1 // op funct7 0x01
40809A13 AAAAAAAA 55555555 00000184 00000000 1 // slli funct7 0x20
4020C3B3 AAAAAAAA 55555555 00000188 00000000 1 // xor funct7 0x20
02C0DA93 AAAAAAAA 55555555 0000018C 00000000 1 // srxi funct7 0x01
008000EF AAAAAAAA 55555555 00000190 00000000 1 // jal
0020D5B3 80000001 00000020 00000194 80000001 0 // srl by 0

/* files.f */
verilog/rv_alu_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu_exec.sv
verilog/rv_result_fifo.sv
verilog/rv_alu_unit.sv
verif/tb_rv_alu_unit.sv

/* Makefile */
# Verilator flow for the RV32I integer-operation unit
# Run from the project root, the testbench reads verif/rv_alu_patterns.mem

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_rv_alu_unit
RTL_TOP   ?= rv_alu_unit
BUILD_DIR ?= obj_dir
SIM_EXE   ?= sim_$(TB_TOP)
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_TEXT ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/$(SIM_EXE): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(SIM_EXE)

sim: $(BUILD_DIR)/$(SIM_EXE)
	@out="$$(./$(BUILD_DIR)/$(SIM_EXE))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_rv_alu_unit.sv */
// Self-checking testbench for rv_alu_unit with RESULT_DEPTH 4
// Items and expected results come from verif/rv_alu_patterns.mem
// Run from the project root so that the pattern path resolves
// Expected rd is taken from bits 11:7 of each instruction word
`timescale 1ns/1ps
`default_nettype none

module tb_rv_alu_unit;
        import rv_alu_pkg::*;

        localparam int NUM_PAT    = 38;
        localparam int WORDS      = 6;                  // Words per pattern line
        localparam int DEPTH      = 4;
        localparam int CLK_PERIOD = 40;
        localparam int PAT_AW     = $clog2(NUM_PAT * WORDS);

        logic            clk;
        logic            reset_i;
        logic            req_valid_i;
        alu_req_t        req_i;
        logic            req_ready_o;
        logic            res_valid_o;
        alu_result_t     res_o;
        logic            res_ready_i;

        logic [31:0]     pat_mem [NUM_PAT * WORDS];
        logic [15:0]     lfsr_q    = 16'd11;           // Back-pressure source
        logic            bp_random = 1'b0;             // Low holds res_ready_i low
        int              out_count = 0;                 // Results taken so far
        int              mon_errs  = 0;                 // Result side
        int              chk_errs  = 0;                 // Stimulus side

        rv_alu_unit #(
                .RESULT_DEPTH (DEPTH)
        ) u_rv_alu_unit (
                .clk         (clk),
                .reset_i     (reset_i),
                .req_valid_i (req_valid_i),
                .req_i       (req_i),
                .req_ready_o (req_ready_o),
                .res_valid_o (res_valid_o),
                .res_o       (res_o),
                .res_ready_i (res_ready_i)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        //////////////////////////////////////////////////
        // Helpers
        //////////////////////////////////////////////////

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_advance(input logic [15:0] s);
                logic fb;
                fb = s[15] ^ s[13] ^ s[12] ^ s[10];
                return {s[14:0], fb};
        endfunction

        task automatic draw_random_bit(output logic bit_o);
                lfsr_q = lfsr_advance(lfsr_q);
                bit_o  = lfsr_q[0];
        endtask

        function automatic logic [31:0] pat_word(input int idx, input int col);
                logic [PAT_AW-1:0] addr;
                addr = PAT_AW'(idx * WORDS + col);
                return pat_mem[addr];
        endfunction

        task automatic present_item(input int idx);
                req_i.instr   = pat_word(idx, 0);
                req_i.rs1_val = pat_word(idx, 1);
                req_i.rs2_val = pat_word(idx, 2);
                req_i.pc      = pat_word(idx, 3);
                req_valid_i   = 1'b1;
        endtask

        // Starts on a falling edge and returns on the falling edge after the handshake
        task automatic send_item(input int idx);
                present_item(idx);
                while (!req_ready_o) begin
                        @(negedge clk);
                end
                @(negedge clk);
                req_valid_i = 1'b0;
        endtask

        task automatic check_result(input alu_result_t got);
                logic [31:0] instr;
                logic [31:0] exp_value;
                logic [31:0] exp_flag;
                if (out_count >= NUM_PAT) begin
                        mon_errs++;
                        $display("A result came out with no item left to match it");
                end else begin
                        instr     = pat_word(out_count, 0);
                        exp_value = pat_word(out_count, 4);
                        exp_flag  = pat_word(out_count, 5);
                        if (got.value != exp_value || got.rd != instr[11:7] ||
                            got.illegal != exp_flag[0]) begin
                                mon_errs++;
                                // Value, rd and illegal flag
                                $display("ERR %0t: item %0d got %h/%0d/%b exp %h/%0d/%b",
                                         $time, out_count, got.value, got.rd, got.illegal,
                                         exp_value, instr[11:7], exp_flag[0]);
                        end
                end
                out_count++;
        endtask

        //////////////////////////////////////////////////
        // Output monitor and back-pressure
        //////////////////////////////////////////////////

        initial begin
                logic        prev_valid;
                logic        prev_ready;
                alu_result_t prev_res;
                logic        bit_a;
                logic        bit_b;
                int          cyc;
                prev_valid  = 1'b0;
                prev_ready  = 1'b0;
                prev_res    = '0;
                cyc         = 0;
                res_ready_i = 1'b0;
                forever begin
                        @(negedge clk);
                        cyc++;
                        if (prev_valid && prev_ready) begin             // Taken at last edge
                                check_result(prev_res);
                        end else if (prev_valid && (!res_valid_o || res_o != prev_res)) begin
                                mon_errs++;
                                $display("ERR %0t: res_o moved while stalled, %h -> %h valid %b",
                                         $time, prev_res, res_o, res_valid_o);
                        end
                        if (!bp_random) begin
                                res_ready_i = 1'b0;
                        end else begin
                                draw_random_bit(bit_a);
                                if (cyc[5]) begin                       // Slow phase with ready ~1/4
                                        draw_random_bit(bit_b);
                                        res_ready_i = bit_a & bit_b;
                                end else begin
                                        res_ready_i = bit_a;
                                end
                        end
                        prev_valid = res_valid_o;
                        prev_ready = res_ready_i;
                        prev_res   = res_o;
                end
        end

        //////////////////////////////////////////////////
        // Stimulus
        //////////////////////////////////////////////////

        initial begin
                reset_i     = 1'b1;
                req_valid_i = 1'b0;
                req_i       = '0;
                $readmemh("verif/rv_alu_patterns.mem", pat_mem);
                repeat (3) @(posedge clk);
                @(negedge clk);
                reset_i = 1'b0;
                if (res_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
                        chk_errs++;
                        $display("ERR %0t: after reset res_valid_o %b req_ready_o %b",
                                 $time, res_valid_o, req_ready_o);
                end

                // Output held off so both stages and the queue fill up
                for (int i = 0; i < 2 + DEPTH; i++) begin
                        send_item(i);
                end
                present_item(2 + DEPTH);
                repeat (2 * DEPTH) begin
                        if (req_ready_o) begin
                                chk_errs++;
                                $display("ERR %0t: req_ready_o high with %0d items in flight",
                                         $time, 2 + DEPTH);
                        end
                        @(negedge clk);
                end

                // Random back-pressure from the next falling edge on
                @(posedge clk);
                bp_random = 1'b1;
                @(negedge clk);
                for (int i = 2 + DEPTH; i < NUM_PAT; i++) begin
                        send_item(i);
                end

                wait (out_count == NUM_PAT);
                repeat (2 * DEPTH) begin
                        @(negedge clk);
                        if (res_valid_o) begin
                                chk_errs++;
                                $display("ERR %0t: res_valid_o high after the last result", $time);
                        end
                end

                $display("Results %0d of %0d, errors %0d (stimulus %0d, results %0d)",
                         out_count, NUM_PAT, chk_errs + mon_errs, chk_errs, mon_errs);
                if (chk_errs + mon_errs == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

        // Watchdog with a bound of 20 cycles per item plus margin
        initial begin
                repeat (NUM_PAT * 20 + 200) @(posedge clk);
                $display("Timeout, the run stalled with %0d of %0d results out",
                         out_count, NUM_PAT);
                $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire

/* verilog/rv_alu_unit.sv */
// RV32I integer-operation unit, decode -> execute -> result queue
// Latency 3 cycles without stalls, up to 2 + RESULT_DEPTH items in flight
// Both ends use valid/ready, data must stay stable until the handshake
`timescale 1ns/1ps
`default_nettype none

module rv_alu_unit #(
        parameter int RESULT_DEPTH = 4
) (
        input  logic                      clk,
        input  logic                      reset_i,
        input  logic                      req_valid_i,
        input  rv_alu_pkg::alu_req_t      req_i,
        output logic                      req_ready_o,
        output logic                      res_valid_o,
        output rv_alu_pkg::alu_result_t   res_o,
        input  logic                      res_ready_i
);
        import rv_alu_pkg::*;

        // Stall chain runs backwards through the ready signals
        logic        dec_valid;
        decoded_t    dec_item;
        logic        dec_ready;
        logic        ex_valid;
        alu_result_t ex_item;
        logic        ex_ready;                          // Queue not full

        rv_decoder u_decoder (
                .clk         (clk),
                .reset_i     (reset_i),
                .req_valid_i (req_valid_i),
                .req_i       (req_i),
                .req_ready_o (req_ready_o),
                .dec_valid_o (dec_valid),
                .dec_o       (dec_item),
                .dec_ready_i (dec_ready)
        );

        rv_alu_exec u_exec (
                .clk         (clk),
                .reset_i     (reset_i),
                .dec_valid_i (dec_valid),
                .dec_i       (dec_item),
                .dec_ready_o (dec_ready),
                .ex_valid_o  (ex_valid),
                .ex_o        (ex_item),
                .ex_ready_i  (ex_ready)
        );

        rv_result_fifo #(
                .DEPTH (RESULT_DEPTH)
        ) u_result (
                .clk         (clk),
                .reset_i     (reset_i),
                .ex_valid_i  (ex_valid),
                .ex_i        (ex_item),
                .ex_ready_o  (ex_ready),
                .res_valid_o (res_valid_o),
                .res_o       (res_o),
                .res_ready_i (res_ready_i)
        );

endmodule

`default_nettype wire

/* verilog/rv_result_fifo.sv */
// Result queue of DEPTH entries with the oldest entry on res_o
// No bypass so a written entry shows on the next cycle
// Read and write may share a cycle and DEPTH need not be a power of two
`timescale 1ns/1ps
`default_nettype none

module rv_result_fifo #(
        parameter int DEPTH = 4
) (
        input  logic                      clk,
        input  logic                      reset_i,
        input  logic                      ex_valid_i,
        input  rv_alu_pkg::alu_result_t   ex_i,
        output logic                      ex_ready_o,
        output logic                      res_valid_o,
        output rv_alu_pkg::alu_result_t   res_o,
        input  logic                      res_ready_i
);
        import rv_alu_pkg::*;

        localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // Pointer width
        localparam int CW = $clog2(DEPTH + 1);                  // Count width

        alu_result_t     mem [DEPTH];
        logic [PW-1:0]   wr_ptr;
        logic [PW-1:0]   rd_ptr;
        logic [CW-1:0]   count;
        logic            wr_en;
        logic            rd_en;

        assign ex_ready_o  = (count != CW'(DEPTH));     // Not full
        assign res_valid_o = (count != '0);
        assign res_o       = mem[rd_ptr];
        assign wr_en       = ex_valid_i && ex_ready_o;
        assign rd_en       = res_valid_o && res_ready_i;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_en) begin
                                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        end
                        if (rd_en) begin
                                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        end
                        count <= count + CW'(wr_en) - CW'(rd_en);  // Both = no change
                end
        end

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        mem[wr_ptr] <= ex_i;            // Write to the tail entry
                end
        end

endmodule

`default_nettype wire

/* verilog/rv_alu_exec.sv */
// Execute stage with one stage register
// Shifts use the low 5 bits of operand B, SLT/SLTU give 0 or 1
`timescale 1ns/1ps
`default_nettype none

module rv_alu_exec (
        input  logic                      clk,
        input  logic                      reset_i,
        input  logic                      dec_valid_i,
        input  rv_alu_pkg::decoded_t      dec_i,
        output logic                      dec_ready_o,
        output logic                      ex_valid_o,
        output rv_alu_pkg::alu_result_t   ex_o,
        input  logic                      ex_ready_i
);
        import rv_alu_pkg::*;

        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic [4:0]      shamt;
        alu_result_t     ex_d;

        // Operand A, zero flag wins over the select
        assign op_a  = dec_i.op_a_zero           ? '0       :
                       (dec_i.op_a_sel == OP_A_PC) ? dec_i.pc : dec_i.rs1_val;
        assign op_b  = (dec_i.op_b_sel == OP_B_IMM) ? dec_i.imm : dec_i.rs2_val;
        assign shamt = op_b[4:0];

        //////////////////////////////////////////////////
        // Arithmetic, logic, compare, shift
        //////////////////////////////////////////////////

        always_comb begin
                ex_d.rd      = dec_i.rd;
                ex_d.illegal = dec_i.illegal;
                case (dec_i.alu_op)
                        ALU_ADD:  ex_d.value = op_a + op_b;
                        ALU_SUB:  ex_d.value = op_a - op_b;     // Wraps modulo 2^32
                        ALU_SLT:  ex_d.value = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                        ALU_SLTU: ex_d.value = {{(XLEN-1){1'b0}}, op_a < op_b};
                        ALU_XOR:  ex_d.value = op_a ^ op_b;
                        ALU_OR:   ex_d.value = op_a | op_b;
                        ALU_AND:  ex_d.value = op_a & op_b;
                        ALU_SLL:  ex_d.value = op_a << shamt;
                        ALU_SRL:  ex_d.value = op_a >> shamt;
                        ALU_SRA:  ex_d.value = $unsigned($signed(op_a) >>> shamt);  // Sign fill
                        default:  ex_d.value = '0;
                endcase
        end

        //////////////////////////////////////////////////
        // Stage register
        //////////////////////////////////////////////////

        assign dec_ready_o = !ex_valid_o || ex_ready_i;

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        ex_valid_o <= 1'b0;
                end else if (dec_ready_o) begin
                        ex_valid_o <= dec_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (dec_valid_i && dec_ready_o) begin
                        ex_o <= ex_d;
                end
        end

endmodule

`default_nettype wire

/* verilog/rv_decoder.sv */
// Decode stage with one stage register
// Illegal encodings leave as ADD 0 + 0 with the illegal flag set
// rd is always taken from bits 11:7 even for illegal items
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
        input  logic                   clk,
        input  logic                   reset_i,
        input  logic                   req_valid_i,
        input  rv_alu_pkg::alu_req_t   req_i,
        output logic                   req_ready_o,
        output logic                   dec_valid_o,
        output rv_alu_pkg::decoded_t   dec_o,
        input  logic                   dec_ready_i
);
        import rv_alu_pkg::*;

        instr_u          instr;
        logic [XLEN-1:0] imm_i;                         // Sign-extended I-type
        logic [XLEN-1:0] imm_u;                         // Upper immediate, low 12 zero
        decoded_t        dec_d;                         // Next register content

        assign instr = req_i.instr;
        assign imm_i = {{(XLEN-12){instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
        assign imm_u = {instr.u.imm_hi, 12'b0};

        //////////////////////////////////////////////////
        // Field decode
        //////////////////////////////////////////////////

        always_comb begin
                // Defaults give a register-register ADD
                dec_d.alu_op    = ALU_ADD;
                dec_d.op_a_sel  = OP_A_RS1;
                dec_d.op_a_zero = 1'b0;
                dec_d.op_b_sel  = OP_B_RS2;
                dec_d.imm       = imm_i;
                dec_d.rs1_val   = req_i.rs1_val;
                dec_d.rs2_val   = req_i.rs2_val;
                dec_d.pc        = req_i.pc;
                dec_d.rd        = instr.ri.rd;
                dec_d.illegal   = 1'b0;

                case (instr.ri.opcode)
                        OPCODE_OP: begin
                                case ({instr.ri.funct7, instr.ri.funct3})
                                        {FUNCT7_BASE, 3'b000}: dec_d.alu_op = ALU_ADD;
                                        {FUNCT7_ALT,  3'b000}: dec_d.alu_op = ALU_SUB;
                                        {FUNCT7_BASE, 3'b010}: dec_d.alu_op = ALU_SLT;
                                        {FUNCT7_BASE, 3'b011}: dec_d.alu_op = ALU_SLTU;
                                        {FUNCT7_BASE, 3'b100}: dec_d.alu_op = ALU_XOR;
                                        {FUNCT7_BASE, 3'b110}: dec_d.alu_op = ALU_OR;
                                        {FUNCT7_BASE, 3'b111}: dec_d.alu_op = ALU_AND;
                                        {FUNCT7_BASE, 3'b001}: dec_d.alu_op = ALU_SLL;
                                        {FUNCT7_BASE, 3'b101}: dec_d.alu_op = ALU_SRL;
                                        {FUNCT7_ALT,  3'b101}: dec_d.alu_op = ALU_SRA;
                                        default:               dec_d.illegal = 1'b1;
                                endcase
                        end
                        OPCODE_OPIMM: begin
                                dec_d.op_b_sel = OP_B_IMM;
                                case (instr.ri.funct3)
                                        3'b000: dec_d.alu_op = ALU_ADD;   // ADDI
                                        3'b010: dec_d.alu_op = ALU_SLT;   // SLTI
                                        3'b011: dec_d.alu_op = ALU_SLTU;  // SLTIU
                                        3'b100: dec_d.alu_op = ALU_XOR;   // XORI
                                        3'b110: dec_d.alu_op = ALU_OR;    // ORI
                                        3'b111: dec_d.alu_op = ALU_AND;   // ANDI
                                        3'b001: begin                     // SLLI
                                                dec_d.alu_op  = ALU_SLL;
                                                dec_d.illegal = (instr.ri.funct7 != FUNCT7_BASE);
                                        end
                                        3'b101: begin                     // SRLI / SRAI
                                                if (instr.ri.funct7 == FUNCT7_BASE) begin
                                                        dec_d.alu_op = ALU_SRL;
                                                end else if (instr.ri.funct7 == FUNCT7_ALT) begin
                                                        dec_d.alu_op = ALU_SRA;
                                                end else begin
                                                        dec_d.illegal = 1'b1;
                                                end
                                        end
                                endcase
                        end
                        OPCODE_LUI: begin       // 0 + upper immediate
                                dec_d.op_a_sel  = OP_A_PC;
                                dec_d.op_a_zero = 1'b1;
                                dec_d.op_b_sel  = OP_B_IMM;
                                dec_d.imm       = imm_u;
                        end
                        OPCODE_AUIPC: begin     // PC + upper immediate
                                dec_d.op_a_sel = OP_A_PC;
                                dec_d.op_b_sel = OP_B_IMM;
                                dec_d.imm      = imm_u;
                        end
                        default: dec_d.illegal = 1'b1;  // Jumps, loads, system, ...
                endcase

                // Illegal items compute 0 + 0
                if (dec_d.illegal) begin
                        dec_d.alu_op    = ALU_ADD;
                        dec_d.op_a_zero = 1'b1;
                        dec_d.op_b_sel  = OP_B_IMM;
                        dec_d.imm       = '0;
                end
        end

        //////////////////////////////////////////////////
        // Stage register
        //////////////////////////////////////////////////

        assign req_ready_o = !dec_valid_o || dec_ready_i;  // Empty or draining

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        dec_valid_o <= 1'b0;
                end else if (req_ready_o) begin
                        dec_valid_o <= req_valid_i;
                end
        end

        always_ff @(posedge clk) begin
                if (req_valid_i && req_ready_o) begin
                        dec_o <= dec_d;                 // Decoded item
                end
        end

endmodule

`default_nettype wire

/* verilog/rv_alu_pkg.sv */
// Shared types and constants for the RV32I integer-operation unit
// Only OP, OP-IMM, LUI and AUIPC are decoded, all other opcodes are illegal
// Field positions follow the RV32I base encoding and are not configurable
`default_nettype none

package rv_alu_pkg;

        localparam int XLEN = 32;                       // Data word width

        //////////////////////////////////////////////////
        // Major opcodes and funct7 values
        //////////////////////////////////////////////////

        localparam logic [6:0] OPCODE_OP    = 7'h33;    // Register-register
        localparam logic [6:0] OPCODE_OPIMM = 7'h13;    // Register-immediate
        localparam logic [6:0] OPCODE_LUI   = 7'h37;
        localparam logic [6:0] OPCODE_AUIPC = 7'h17;

        localparam logic [6:0] FUNCT7_BASE  = 7'h00;
        localparam logic [6:0] FUNCT7_ALT   = 7'h20;    // SUB and SRA variants

        typedef enum logic [3:0] {
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
                ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
        } alu_op_e;

        typedef enum logic {OP_A_RS1, OP_A_PC} op_a_sel_e;
        typedef enum logic {OP_B_RS2, OP_B_IMM} op_b_sel_e;

        //////////////////////////////////////////////////
        // Instruction word, two decodings
        //////////////////////////////////////////////////

        typedef struct packed {
                logic [6:0] funct7;     // Upper I-type immediate bits for OP-IMM
                logic [4:0] rs2;        // Low immediate bits / shift amount
                logic [4:0] rs1;
                logic [2:0] funct3;
                logic [4:0] rd;
                logic [6:0] opcode;
        } instr_ri_t;

        typedef struct packed {
                logic [19:0] imm_hi;    // U-type upper immediate
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } instr_uf_t;

        typedef union packed {
                instr_ri_t ri;
                instr_uf_t u;
        } instr_u;

        //////////////////////////////////////////////////
        // Stage items
        //////////////////////////////////////////////////

        typedef struct packed {
                instr_u            instr;
                logic [XLEN-1:0]   rs1_val;
                logic [XLEN-1:0]   rs2_val;
                logic [XLEN-1:0]   pc;
        } alu_req_t;

        typedef struct packed {
                alu_op_e           alu_op;
                op_a_sel_e         op_a_sel;
                logic              op_a_zero;   // Forces operand A to 0 (LUI)
                op_b_sel_e         op_b_sel;
                logic [XLEN-1:0]   imm;
                logic [XLEN-1:0]   rs1_val;
                logic [XLEN-1:0]   rs2_val;
                logic [XLEN-1:0]   pc;
                logic [4:0]        rd;
                logic              illegal;
        } decoded_t;

        typedef struct packed {
                logic [XLEN-1:0]   value;
                logic [4:0]        rd;
                logic              illegal;     // Value is 0 when set
        } alu_result_t;

endpackage

`default_nettype wire
